/* logic/jac_pkg.sv */
// shared widths, counts and types of the jacobian engine, referenced by scoped names
package jac_pkg;

	// q16.16 fixed point
	localparam int FIX_W = 32;
	localparam int FRAC_BITS = 16;

	localparam int NUM_JOINTS = 6;
	localparam int JAC_ROWS = 6;

	// load stream layout: z first, then six row-major 3x4 frames
	localparam int Z_WORDS = 3;
	localparam int FRAME_WORDS = 12;
	localparam int ROW_WORDS = 4;
	localparam int TRANS_COL = 3;
	localparam int LOAD_WORDS = Z_WORDS + NUM_JOINTS * FRAME_WORDS;
	localparam int WORD_W = $clog2(LOAD_WORDS);

	localparam int MULT_LAT = 2;

	typedef logic signed [FIX_W-1:0] fix_t;
	typedef logic signed [2*FIX_W-1:0] prod_t;
	typedef logic [2:0] joint_t;
	typedef logic [1:0] comp_t;
	typedef logic [2:0] row_t;
	typedef logic [2:0] count_t;
	typedef logic [NUM_JOINTS-1:0] jmask_t;
	typedef logic [WORD_W-1:0] word_t;

	// multiplier client tag
	typedef logic [0:0] client_t;
	localparam client_t CLIENT_AX = 1'b0;
	localparam client_t CLIENT_CR = 1'b1;

endpackage

/* logic/fixed_mult.sv */
// two-stage q16.16 multiplier; a client tag rides along so the arbiter can route results
`timescale 1ns/100ps

module fixed_mult (
	input  logic             i,
	input  logic             rst,
	input  logic             in_valid,
	input  jac_pkg::client_t in_tag,
	input  jac_pkg::fix_t    a,
	input  jac_pkg::fix_t    b,
	output logic             out_valid,
	output jac_pkg::client_t out_tag,
	output jac_pkg::fix_t    out_data
);

	jac_pkg::prod_t prod_q;
	logic [jac_pkg::MULT_LAT-1:0] vld_pipe;
	jac_pkg::client_t tag_pipe [jac_pkg::MULT_LAT];

	// stage 1 keeps the full product, stage 2 shifts and truncates
	always_ff @(posedge i) begin
		prod_q <= jac_pkg::prod_t'(a) * jac_pkg::prod_t'(b);
		out_data <= jac_pkg::fix_t'(prod_q >>> jac_pkg::FRAC_BITS);
	end

	always_ff @(posedge i) begin
		if (rst) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[jac_pkg::MULT_LAT-2:0], in_valid};
		end
	end

	always_ff @(posedge i) begin
		tag_pipe[0] <= in_tag;
		for (int k = 1; k < jac_pkg::MULT_LAT; k++) begin
			tag_pipe[k] <= tag_pipe[k-1];
		end
	end

	assign out_valid = vld_pipe[jac_pkg::MULT_LAT-1];
	assign out_tag = tag_pipe[jac_pkg::MULT_LAT-1];

endmodule

/* logic/mult_arbiter.sv */
// round-robin sharing of one multiplier between the axis unit and the cross unit
`timescale 1ns/100ps

module mult_arbiter (
	input  logic          i,
	input  logic          rst,
	input  logic          ax_req_valid,
	output logic          ax_req_ready,
	input  jac_pkg::fix_t ax_req_a,
	input  jac_pkg::fix_t ax_req_b,
	input  logic          cr_req_valid,
	output logic          cr_req_ready,
	input  jac_pkg::fix_t cr_req_a,
	input  jac_pkg::fix_t cr_req_b,
	output logic          ax_rsp_valid,
	output logic          cr_rsp_valid,
	output jac_pkg::fix_t rsp_data
);

	jac_pkg::client_t last_grant;
	jac_pkg::client_t in_tag;
	jac_pkg::client_t mult_tag;
	jac_pkg::fix_t mult_a;
	jac_pkg::fix_t mult_b;
	logic grant_ax;
	logic grant_cr;
	logic mult_in_valid;
	logic mult_valid;

	// axis unit wins unless both wait and it had the previous grant
	assign grant_ax = ax_req_valid && (!cr_req_valid || last_grant == jac_pkg::CLIENT_CR);
	assign grant_cr = cr_req_valid && !grant_ax;
	assign ax_req_ready = grant_ax;
	assign cr_req_ready = grant_cr;

	assign mult_in_valid = grant_ax || grant_cr;
	assign in_tag = grant_cr ? jac_pkg::CLIENT_CR : jac_pkg::CLIENT_AX;
	assign mult_a = grant_cr ? cr_req_a : ax_req_a;
	assign mult_b = grant_cr ? cr_req_b : ax_req_b;

	always_ff @(posedge i) begin
		if (rst) begin
			last_grant <= jac_pkg::CLIENT_CR;
		end else if (mult_in_valid) begin
			last_grant <= in_tag;
		end
	end

	fixed_mult u_fixed_mult (
		.i        (i),
		.rst      (rst),
		.in_valid (mult_in_valid),
		.in_tag   (in_tag),
		.a        (mult_a),
		.b        (mult_b),
		.out_valid(mult_valid),
		.out_tag  (mult_tag),
		.out_data (rsp_data)
	);

	// returned tag picks which client sees the result
	assign ax_rsp_valid = mult_valid && mult_tag == jac_pkg::CLIENT_AX;
	assign cr_rsp_valid = mult_valid && mult_tag == jac_pkg::CLIENT_CR;

endmodule

/* logic/frame_store.sv */
// load-stream sink holding z, the six frames and the joint mask; serves rotation and distance reads
`timescale 1ns/100ps

module frame_store (
	input  logic           i,
	input  logic           rst,
	input  logic           frame_valid,
	output logic           frame_ready,
	input  jac_pkg::fix_t  frame_data,
	input  jac_pkg::jmask_t joint_types,
	input  logic           job_done,
	output logic           loaded,
	output jac_pkg::jmask_t mask,
	input  jac_pkg::joint_t rot_joint,
	input  jac_pkg::comp_t rot_row,
	input  jac_pkg::comp_t rot_col,
	output jac_pkg::fix_t  rot_data,
	input  jac_pkg::joint_t dist_joint,
	input  jac_pkg::comp_t dist_comp,
	output jac_pkg::fix_t  dist_data
);

	jac_pkg::fix_t words [jac_pkg::LOAD_WORDS];
	jac_pkg::word_t wr_cnt;
	jac_pkg::fix_t end_pos;
	jac_pkg::fix_t origin;
	logic accept;
	logic last_word;

	// word address of one element of a frame
	function automatic jac_pkg::word_t frame_word(input int frame, input int row, input int col);
		return jac_pkg::word_t'(jac_pkg::Z_WORDS + frame * jac_pkg::FRAME_WORDS
			+ row * jac_pkg::ROW_WORDS + col);
	endfunction

	assign frame_ready = !loaded;
	assign accept = frame_valid && frame_ready;
	assign last_word = wr_cnt == jac_pkg::word_t'(jac_pkg::LOAD_WORDS - 1);

	always_ff @(posedge i) begin
		if (accept) begin
			words[wr_cnt] <= frame_data;
		end
		if (accept && last_word) begin
			mask <= joint_types;
		end
	end

	always_ff @(posedge i) begin
		if (rst) begin
			wr_cnt <= '0;
			loaded <= 1'b0;
		end else begin
			if (accept) begin
				wr_cnt <= last_word ? '0 : wr_cnt + 1'b1;
			end
			if (accept && last_word) begin
				loaded <= 1'b1;
			end else if (job_done) begin
				loaded <= 1'b0;
			end
		end
	end

	// joint 0 reads z by column, joint j reads the rotation of frame j-1
	assign rot_data = (rot_joint == '0) ? words[rot_col]
		: words[frame_word(int'(rot_joint) - 1, rot_row, rot_col)];

	// end effector position minus joint origin, origin of joint 0 is zero
	assign end_pos = words[frame_word(jac_pkg::NUM_JOINTS - 1, dist_comp, jac_pkg::TRANS_COL)];
	assign origin = (dist_joint == '0) ? '0
		: words[frame_word(int'(dist_joint) - 1, dist_comp, jac_pkg::TRANS_COL)];
	assign dist_data = end_pos - origin;

endmodule

/* logic/axis_unit.sv */
// joint axis engine: axis 0 is z, axis j is R of frame j-1 times z via the shared multiplier
`timescale 1ns/100ps

module axis_unit (
	input  logic            i,
	input  logic            rst,
	input  logic            loaded,
	output jac_pkg::joint_t rot_joint,
	output jac_pkg::comp_t  rot_row,
	output jac_pkg::comp_t  rot_col,
	input  jac_pkg::fix_t   rot_data,
	output logic            req_valid,
	input  logic            req_ready,
	output jac_pkg::fix_t   req_a,
	output jac_pkg::fix_t   req_b,
	input  logic            rsp_valid,
	input  jac_pkg::fix_t   rsp_data,
	output jac_pkg::count_t axis_count,
	input  jac_pkg::joint_t axis_joint,
	input  jac_pkg::comp_t  axis_comp,
	output jac_pkg::fix_t   axis_data,
	input  jac_pkg::joint_t col_joint,
	input  jac_pkg::comp_t  col_comp,
	output jac_pkg::fix_t   col_data,
	input  logic            job_done
);

	typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_DRAIN} state_t;

	state_t state;
	jac_pkg::fix_t axes [jac_pkg::NUM_JOINTS][3];
	jac_pkg::joint_t iss_joint;
	jac_pkg::comp_t iss_row;
	jac_pkg::comp_t iss_k;
	jac_pkg::joint_t rsp_joint;
	jac_pkg::comp_t rsp_row;
	jac_pkg::comp_t rsp_k;
	jac_pkg::fix_t acc;
	jac_pkg::fix_t sum;
	logic start;
	logic iss_last;

	assign rot_joint = iss_joint;
	assign rot_row = iss_row;
	assign rot_col = iss_k;

	assign req_valid = state == ST_ISSUE;
	assign req_a = rot_data;
	assign req_b = axes[0][iss_k];

	assign start = state == ST_IDLE && loaded && axis_count == '0;
	assign iss_last = iss_joint == jac_pkg::joint_t'(jac_pkg::NUM_JOINTS - 1)
		&& iss_row == 2'd2 && iss_k == 2'd2;
	assign sum = (rsp_k == '0) ? rsp_data : acc + rsp_data;

	assign axis_data = axes[axis_joint][axis_comp];
	assign col_data = axes[col_joint][col_comp];

	// while idle the read port sweeps z, so axis 0 is current when loaded rises
	always_ff @(posedge i) begin
		if (rst) begin
			state <= ST_IDLE;
			iss_joint <= '0;
			iss_row <= '0;
			iss_k <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					iss_k <= (iss_k == 2'd2) ? '0 : iss_k + 1'b1;
					if (start) begin
						state <= ST_ISSUE;
						iss_joint <= 3'd1;
						iss_k <= '0;
					end
				end
				ST_ISSUE: begin
					if (req_ready) begin
						if (iss_k != 2'd2) begin
							iss_k <= iss_k + 1'b1;
						end else begin
							iss_k <= '0;
							if (iss_row != 2'd2) begin
								iss_row <= iss_row + 1'b1;
							end else begin
								iss_row <= '0;
								iss_joint <= iss_joint + 1'b1;
							end
						end
						if (iss_last) begin
							state <= ST_DRAIN;
							iss_joint <= '0;
						end
					end
				end
				ST_DRAIN: begin
					if (axis_count == jac_pkg::count_t'(jac_pkg::NUM_JOINTS)) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (state == ST_IDLE) begin
			axes[0][iss_k] <= rot_data;
		end
		if (rsp_valid) begin
			acc <= sum;
			if (rsp_k == 2'd2) begin
				axes[rsp_joint][rsp_row] <= sum;
			end
		end
	end

	// results return in issue order, so counters track joint, row and term
	always_ff @(posedge i) begin
		if (rst) begin
			rsp_joint <= 3'd1;
			rsp_row <= '0;
			rsp_k <= '0;
			axis_count <= '0;
		end else begin
			if (start) begin
				axis_count <= 3'd1;
			end else if (job_done) begin
				axis_count <= '0;
			end
			if (rsp_valid) begin
				if (rsp_k != 2'd2) begin
					rsp_k <= rsp_k + 1'b1;
				end else begin
					rsp_k <= '0;
					if (rsp_row != 2'd2) begin
						rsp_row <= rsp_row + 1'b1;
					end else begin
						rsp_row <= '0;
						axis_count <= axis_count + 1'b1;
						if (rsp_joint == jac_pkg::joint_t'(jac_pkg::NUM_JOINTS - 1)) begin
							rsp_joint <= 3'd1;
						end else begin
							rsp_joint <= rsp_joint + 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

/* logic/cross_unit.sv */
// axis x distance per joint, started as soon as the joint's axis is finished
`timescale 1ns/100ps

module cross_unit (
	input  logic            i,
	input  logic            rst,
	input  jac_pkg::count_t axis_count,
	output jac_pkg::joint_t axis_joint,
	output jac_pkg::comp_t  axis_comp,
	input  jac_pkg::fix_t   axis_data,
	output jac_pkg::joint_t dist_joint,
	output jac_pkg::comp_t  dist_comp,
	input  jac_pkg::fix_t   dist_data,
	output logic            req_valid,
	input  logic            req_ready,
	output jac_pkg::fix_t   req_a,
	output jac_pkg::fix_t   req_b,
	input  logic            rsp_valid,
	input  jac_pkg::fix_t   rsp_data,
	output jac_pkg::count_t cross_count,
	input  jac_pkg::joint_t cross_joint,
	input  jac_pkg::comp_t  cross_comp,
	output jac_pkg::fix_t   cross_data,
	input  logic            job_done
);

	jac_pkg::fix_t crosses [jac_pkg::NUM_JOINTS][3];
	jac_pkg::joint_t iss_joint;
	logic [2:0] iss_prod;
	jac_pkg::joint_t rsp_joint;
	logic [2:0] rsp_prod;
	jac_pkg::fix_t first;
	jac_pkg::comp_t a_comp;
	jac_pkg::comp_t d_comp;

	// product order ay.dz az.dy az.dx ax.dz ax.dy ay.dx
	always_comb begin
		case (iss_prod)
			3'd0: begin a_comp = 2'd1; d_comp = 2'd2; end
			3'd1: begin a_comp = 2'd2; d_comp = 2'd1; end
			3'd2: begin a_comp = 2'd2; d_comp = 2'd0; end
			3'd3: begin a_comp = 2'd0; d_comp = 2'd2; end
			3'd4: begin a_comp = 2'd0; d_comp = 2'd1; end
			default: begin a_comp = 2'd1; d_comp = 2'd0; end
		endcase
	end

	assign axis_joint = iss_joint;
	assign axis_comp = a_comp;
	assign dist_joint = iss_joint;
	assign dist_comp = d_comp;

	// joint j may go once its axis is counted
	assign req_valid = axis_count > iss_joint;
	assign req_a = axis_data;
	assign req_b = dist_data;

	assign cross_data = crosses[cross_joint][cross_comp];

	always_ff @(posedge i) begin
		if (rst || job_done) begin
			iss_joint <= '0;
			iss_prod <= '0;
		end else if (req_valid && req_ready) begin
			if (iss_prod == 3'd5) begin
				iss_prod <= '0;
				iss_joint <= iss_joint + 1'b1;
			end else begin
				iss_prod <= iss_prod + 1'b1;
			end
		end
	end

	always_ff @(posedge i) begin
		if (rst || job_done) begin
			rsp_joint <= '0;
			rsp_prod <= '0;
			cross_count <= '0;
		end else if (rsp_valid) begin
			if (rsp_prod == 3'd5) begin
				rsp_prod <= '0;
				rsp_joint <= rsp_joint + 1'b1;
				cross_count <= cross_count + 1'b1;
			end else begin
				rsp_prod <= rsp_prod + 1'b1;
			end
		end
	end

	// even results are held, odd ones complete a component
	always_ff @(posedge i) begin
		if (rsp_valid) begin
			if (!rsp_prod[0]) begin
				first <= rsp_data;
			end else begin
				crosses[rsp_joint][rsp_prod[2:1]] <= first - rsp_data;
			end
		end
	end

endmodule

/* logic/column_out.sv */
// jacobian result streamer, column by column, with a registered stage that holds on back-pressure
`timescale 1ns/100ps

module column_out (
	input  logic            i,
	input  logic            rst,
	input  jac_pkg::count_t cross_count,
	input  jac_pkg::jmask_t mask,
	output jac_pkg::joint_t axis_joint,
	output jac_pkg::comp_t  axis_comp,
	input  jac_pkg::fix_t   axis_data,
	output jac_pkg::joint_t cross_joint,
	output jac_pkg::comp_t  cross_comp,
	input  jac_pkg::fix_t   cross_data,
	output logic            jac_valid,
	input  logic            jac_ready,
	output jac_pkg::fix_t   jac_data,
	output jac_pkg::joint_t jac_joint,
	output jac_pkg::row_t   jac_row,
	output logic            job_done
);

	typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_LAST} state_t;

	state_t state;
	jac_pkg::joint_t sel_joint;
	jac_pkg::row_t sel_row;
	jac_pkg::comp_t sel_comp;
	jac_pkg::fix_t elem;
	logic upper;
	logic advance;

	assign upper = sel_row >= 3'd3;
	assign sel_comp = upper ? jac_pkg::comp_t'(sel_row - 3'd3) : jac_pkg::comp_t'(sel_row);

	assign axis_joint = sel_joint;
	assign axis_comp = sel_comp;
	assign cross_joint = sel_joint;
	assign cross_comp = sel_comp;

	// rotational: cross over axis, prismatic: axis over zeros
	always_comb begin
		if (mask[sel_joint]) begin
			elem = upper ? axis_data : cross_data;
		end else begin
			elem = upper ? '0 : axis_data;
		end
	end

	assign advance = state == ST_RUN && (!jac_valid || jac_ready);
	assign job_done = state == ST_LAST && jac_ready;

	always_ff @(posedge i) begin
		if (rst) begin
			state <= ST_IDLE;
			jac_valid <= 1'b0;
			sel_joint <= '0;
			sel_row <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cross_count == jac_pkg::count_t'(jac_pkg::NUM_JOINTS)) begin
						state <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (advance) begin
						jac_valid <= 1'b1;
						if (sel_row == jac_pkg::row_t'(jac_pkg::JAC_ROWS - 1)) begin
							sel_row <= '0;
							if (sel_joint == jac_pkg::joint_t'(jac_pkg::NUM_JOINTS - 1)) begin
								sel_joint <= '0;
								state <= ST_LAST;
							end else begin
								sel_joint <= sel_joint + 1'b1;
							end
						end else begin
							sel_row <= sel_row + 1'b1;
						end
					end
				end
				ST_LAST: begin
					// element 35 is on the output, wait for its handshake
					if (jac_ready) begin
						jac_valid <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (advance) begin
			jac_data <= elem;
			jac_joint <= sel_joint;
			jac_row <= sel_row;
		end
	end

endmodule

/* logic/jacobian_top.sv */
// jacobian engine top level connecting the store, the axis and cross units, the arbiter and the output
`timescale 1ns/100ps

module jacobian_top (
	input  logic            i,
	input  logic            rst,
	input  logic            frame_valid,
	output logic            frame_ready,
	input  jac_pkg::fix_t   frame_data,
	input  jac_pkg::jmask_t joint_types,
	output logic            jac_valid,
	input  logic            jac_ready,
	output jac_pkg::fix_t   jac_data,
	output jac_pkg::joint_t jac_joint,
	output jac_pkg::row_t   jac_row
);

	logic loaded;
	logic job_done;
	jac_pkg::jmask_t mask;
	jac_pkg::joint_t rot_joint;
	jac_pkg::comp_t rot_row;
	jac_pkg::comp_t rot_col;
	jac_pkg::fix_t rot_data;
	jac_pkg::joint_t dist_joint;
	jac_pkg::comp_t dist_comp;
	jac_pkg::fix_t dist_data;
	jac_pkg::count_t axis_count;
	jac_pkg::count_t cross_count;
	// axis reads, one port for the cross unit and one for the output
	jac_pkg::joint_t cr_axis_joint;
	jac_pkg::comp_t cr_axis_comp;
	jac_pkg::fix_t cr_axis_data;
	jac_pkg::joint_t co_axis_joint;
	jac_pkg::comp_t co_axis_comp;
	jac_pkg::fix_t co_axis_data;
	jac_pkg::joint_t cross_joint;
	jac_pkg::comp_t cross_comp;
	jac_pkg::fix_t cross_data;
	logic ax_req_valid;
	logic ax_req_ready;
	jac_pkg::fix_t ax_req_a;
	jac_pkg::fix_t ax_req_b;
	logic cr_req_valid;
	logic cr_req_ready;
	jac_pkg::fix_t cr_req_a;
	jac_pkg::fix_t cr_req_b;
	logic ax_rsp_valid;
	logic cr_rsp_valid;
	jac_pkg::fix_t rsp_data;

	frame_store u_frame_store (
		.i(i), .rst(rst),
		.frame_valid(frame_valid), .frame_ready(frame_ready),
		.frame_data(frame_data), .joint_types(joint_types),
		.job_done(job_done), .loaded(loaded), .mask(mask),
		.rot_joint(rot_joint), .rot_row(rot_row), .rot_col(rot_col), .rot_data(rot_data),
		.dist_joint(dist_joint), .dist_comp(dist_comp), .dist_data(dist_data)
	);

	axis_unit u_axis_unit (
		.i(i), .rst(rst), .loaded(loaded),
		.rot_joint(rot_joint), .rot_row(rot_row), .rot_col(rot_col), .rot_data(rot_data),
		.req_valid(ax_req_valid), .req_ready(ax_req_ready),
		.req_a(ax_req_a), .req_b(ax_req_b),
		.rsp_valid(ax_rsp_valid), .rsp_data(rsp_data),
		.axis_count(axis_count),
		.axis_joint(cr_axis_joint), .axis_comp(cr_axis_comp), .axis_data(cr_axis_data),
		.col_joint(co_axis_joint), .col_comp(co_axis_comp), .col_data(co_axis_data),
		.job_done(job_done)
	);

	cross_unit u_cross_unit (
		.i(i), .rst(rst), .axis_count(axis_count),
		.axis_joint(cr_axis_joint), .axis_comp(cr_axis_comp), .axis_data(cr_axis_data),
		.dist_joint(dist_joint), .dist_comp(dist_comp), .dist_data(dist_data),
		.req_valid(cr_req_valid), .req_ready(cr_req_ready),
		.req_a(cr_req_a), .req_b(cr_req_b),
		.rsp_valid(cr_rsp_valid), .rsp_data(rsp_data),
		.cross_count(cross_count),
		.cross_joint(cross_joint), .cross_comp(cross_comp), .cross_data(cross_data),
		.job_done(job_done)
	);

	mult_arbiter u_mult_arbiter (
		.i(i), .rst(rst),
		.ax_req_valid(ax_req_valid), .ax_req_ready(ax_req_ready),
		.ax_req_a(ax_req_a), .ax_req_b(ax_req_b),
		.cr_req_valid(cr_req_valid), .cr_req_ready(cr_req_ready),
		.cr_req_a(cr_req_a), .cr_req_b(cr_req_b),
		.ax_rsp_valid(ax_rsp_valid), .cr_rsp_valid(cr_rsp_valid), .rsp_data(rsp_data)
	);

	column_out u_column_out (
		.i(i), .rst(rst), .cross_count(cross_count), .mask(mask),
		.axis_joint(co_axis_joint), .axis_comp(co_axis_comp), .axis_data(co_axis_data),
		.cross_joint(cross_joint), .cross_comp(cross_comp), .cross_data(cross_data),
		.jac_valid(jac_valid), .jac_ready(jac_ready), .jac_data(jac_data),
		.jac_joint(jac_joint), .jac_row(jac_row), .job_done(job_done)
	);

endmodule

/* test/jacobian_tb.sv */
// testbench for jacobian_top that checks random jobs against a model of the q16.16 jacobian rules
`timescale 1ns/100ps

module jacobian_tb;

	// each job stays well under this many cycles, gaps and stalls included
	localparam int JOB_COUNT = 20;
	localparam int JOB_CYCLES = 900;
	localparam int TIMEOUT = JOB_COUNT * JOB_CYCLES;
	localparam int RAND_JOBS = 8;
	// operands stay within +-4.0
	localparam int VAL_SPAN = (4 << jac_pkg::FRAC_BITS) + 1;

	logic i;
	logic rst;
	logic frame_valid;
	logic frame_ready;
	jac_pkg::fix_t frame_data;
	jac_pkg::jmask_t joint_types;
	logic jac_valid;
	logic jac_ready;
	jac_pkg::fix_t jac_data;
	jac_pkg::joint_t jac_joint;
	jac_pkg::row_t jac_row;

	integer seed;
	int errors;
	int checks;
	int tests;
	int test_start_errors;
	int cycles;
	jac_pkg::fix_t cur_words [jac_pkg::LOAD_WORDS];
	jac_pkg::jmask_t cur_mask;
	jac_pkg::fix_t job_words [RAND_JOBS][jac_pkg::LOAD_WORDS];
	jac_pkg::jmask_t job_masks [RAND_JOBS];
	jac_pkg::fix_t exp_q [$];

	jacobian_top u_jacobian_top (
		.i(i), .rst(rst),
		.frame_valid(frame_valid), .frame_ready(frame_ready),
		.frame_data(frame_data), .joint_types(joint_types),
		.jac_valid(jac_valid), .jac_ready(jac_ready), .jac_data(jac_data),
		.jac_joint(jac_joint), .jac_row(jac_row)
	);

	initial begin
		i = 1'b0;
		forever #20 i = ~i;
	end

	always @(posedge i) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Test failed");
			$finish;
		end
	end

	// full 64-bit product, arithmetic shift by 16, low 32 bits kept
	function automatic jac_pkg::fix_t fix_mul(input jac_pkg::fix_t a, input jac_pkg::fix_t b);
		longint wide;
		wide = longint'(a) * longint'(b);
		return wide[47:16];
	endfunction

	function automatic jac_pkg::fix_t rand_fix();
		jac_pkg::fix_t v;
		v = $random(seed) % VAL_SPAN;
		return v;
	endfunction

	task automatic note_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic check_value(input jac_pkg::fix_t got, input jac_pkg::fix_t exp,
		input string sig);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic match_index(input jac_pkg::joint_t got_j, input jac_pkg::row_t got_r,
		input jac_pkg::joint_t exp_j, input jac_pkg::row_t exp_r);
		checks++;
		if (got_j !== exp_j) begin
			$display("Mismatch at %0t: jac_joint got %0d expected %0d", $time, got_j, exp_j);
			errors++;
		end
		if (got_r !== exp_r) begin
			$display("Mismatch at %0t: jac_row got %0d expected %0d", $time, got_r, exp_r);
			errors++;
		end
	endtask

	task automatic make_job(input jac_pkg::jmask_t m);
		for (int n = 0; n < jac_pkg::LOAD_WORDS; n++) begin
			cur_words[n] = rand_fix();
		end
		cur_mask = m;
	endtask

	// expected elements, joint by joint, rows 0 to 5
	task automatic model_job();
		jac_pkg::fix_t z [3];
		jac_pkg::fix_t ax [3];
		jac_pkg::fix_t dv [3];
		jac_pkg::fix_t cr [3];
		jac_pkg::fix_t org;
		jac_pkg::fix_t acc;
		int base;
		for (int c = 0; c < 3; c++) begin
			z[c] = cur_words[c];
		end
		for (int j = 0; j < jac_pkg::NUM_JOINTS; j++) begin
			for (int r = 0; r < 3; r++) begin
				base = 3 + (j - 1) * 12 + r * 4;
				if (j == 0) begin
					ax[r] = z[r];
					org = '0;
				end else begin
					acc = '0;
					for (int k = 0; k < 3; k++) begin
						acc = acc + fix_mul(cur_words[base + k], z[k]);
					end
					ax[r] = acc;
					org = cur_words[base + 3];
				end
				dv[r] = cur_words[3 + 5 * 12 + r * 4 + 3] - org;
			end
			cr[0] = fix_mul(ax[1], dv[2]) - fix_mul(ax[2], dv[1]);
			cr[1] = fix_mul(ax[2], dv[0]) - fix_mul(ax[0], dv[2]);
			cr[2] = fix_mul(ax[0], dv[1]) - fix_mul(ax[1], dv[0]);
			for (int r = 0; r < 3; r++) begin
				exp_q.push_back(cur_mask[j] ? cr[r] : ax[r]);
			end
			for (int r = 0; r < 3; r++) begin
				exp_q.push_back(cur_mask[j] ? ax[r] : '0);
			end
		end
	endtask

	task automatic apply_reset();
		rst <= 1'b1;
		frame_valid <= 1'b0;
		jac_ready <= 1'b1;
		repeat (10) @(posedge i);
		rst <= 1'b0;
		@(posedge i);
		if (frame_ready !== 1'b1) note_failure("frame_ready is not high after reset");
		if (jac_valid !== 1'b0) note_failure("jac_valid is not low after reset");
	endtask

	task automatic load_frames(input logic gap_en);
		int gap;
		for (int n = 0; n < jac_pkg::LOAD_WORDS; n++) begin
			gap = gap_en ? ($random(seed) & 3) : 0;
			if (gap != 0) begin
				frame_valid <= 1'b0;
				repeat (gap) @(posedge i);
			end
			frame_valid <= 1'b1;
			frame_data <= cur_words[n];
			// the mask only counts together with the last word
			joint_types <= (n == jac_pkg::LOAD_WORDS - 1) ? cur_mask : ~cur_mask;
			@(posedge i);
			while (!frame_ready) @(posedge i);
		end
		frame_valid <= 1'b0;
		joint_types <= ~cur_mask;
	endtask

	task automatic collect_results(input logic stall_en);
		jac_pkg::joint_t exp_j;
		jac_pkg::row_t exp_r;
		jac_pkg::fix_t exp_d;
		exp_j = '0;
		exp_r = '0;
		jac_ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
		while (exp_q.size() != 0) begin
			@(posedge i);
			if (frame_ready !== 1'b0) note_failure("frame_ready went high before the last element");
			if (jac_valid && jac_ready) begin
				exp_d = exp_q.pop_front();
				check_value(jac_data, exp_d, "jac_data");
				match_index(jac_joint, jac_row, exp_j, exp_r);
				if (exp_r == 3'd5) begin
					exp_r = '0;
					exp_j = exp_j + 1'b1;
				end else begin
					exp_r = exp_r + 1'b1;
				end
			end
			jac_ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
		end
		jac_ready <= 1'b1;
		@(posedge i);
		// a 37th element or a stuck job would show here
		if (jac_valid !== 1'b0) note_failure("jac_valid is still high after the 36th element");
		if (frame_ready !== 1'b1) note_failure("frame_ready did not return high after the job");
	endtask

	task automatic run_job(input logic gap_en, input logic stall_en);
		model_job();
		load_frames(gap_en);
		collect_results(stall_en);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	initial begin
		integer r;
		seed = 3;
		errors = 0;
		checks = 0;
		tests = 0;
		test_start_errors = 0;
		cycles = 0;
		rst = 1'b1;
		frame_valid = 1'b0;
		frame_data = '0;
		joint_types = '0;
		jac_ready = 1'b1;

		apply_reset();
		end_test("reset state");

		make_job(6'b111111);
		run_job(1'b0, 1'b0);
		end_test("all rotational");

		make_job(6'b000000);
		run_job(1'b0, 1'b0);
		end_test("all prismatic");

		// one set of random jobs, replayed later with gaps and stalls
		for (int n = 0; n < RAND_JOBS; n++) begin
			r = $random(seed);
			make_job(r[jac_pkg::NUM_JOINTS-1:0]);
			job_words[n] = cur_words;
			job_masks[n] = cur_mask;
		end
		for (int n = 0; n < RAND_JOBS; n++) begin
			cur_words = job_words[n];
			cur_mask = job_masks[n];
			run_job(1'b0, 1'b0);
		end
		end_test("random jobs back to back");

		for (int n = 0; n < RAND_JOBS; n++) begin
			cur_words = job_words[n];
			cur_mask = job_masks[n];
			run_job(1'b1, 1'b1);
		end
		end_test("random jobs with gaps and stalls");

		// abort while the multiplier is still busy
		r = $random(seed);
		make_job(r[jac_pkg::NUM_JOINTS-1:0]);
		load_frames(1'b1);
		repeat (20) @(posedge i);
		apply_reset();
		r = $random(seed);
		make_job(r[jac_pkg::NUM_JOINTS-1:0]);
		run_job(1'b1, 1'b1);
		end_test("reset in the middle of a job");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* build.f */
logic/jac_pkg.sv
logic/fixed_mult.sv
logic/mult_arbiter.sv
logic/frame_store.sv
logic/axis_unit.sv
logic/cross_unit.sv
logic/column_out.sv
logic/jacobian_top.sv
test/jacobian_tb.sv
